// File: logic/trap_pkg.sv
// Machine-mode trap unit package with CSR addresses, privilege levels and fixed constants.
`default_nettype none

package trap_pkg;

    // Data word width.
    localparam int xlen = 32;
    // Width of an mcause number.
    localparam int cause_w = 5;
    // Width of a CSR address.
    localparam int csr_addr_w = 12;

    // Implemented machine CSR addresses.
    typedef enum logic [csr_addr_w-1:0] {
        csr_mstatus    = 12'h300,
        csr_misa       = 12'h301,
        csr_medeleg    = 12'h302,
        csr_mideleg    = 12'h303,
        csr_mie        = 12'h304,
        csr_mtvec      = 12'h305,
        csr_mstatush   = 12'h310,
        csr_mscratch   = 12'h340,
        csr_mepc       = 12'h341,
        csr_mcause     = 12'h342,
        csr_mtval      = 12'h343,
        csr_mip        = 12'h344,
        csr_mvendorid  = 12'hf11,
        csr_marchid    = 12'hf12,
        csr_mimpid     = 12'hf13,
        csr_mhartid    = 12'hf14,
        csr_mconfigptr = 12'hf15
    } csr_addr_e;

    // Privilege levels, U and M only.
    typedef enum logic [1:0] {
        priv_user    = 2'd0,
        priv_machine = 2'd3
    } priv_e;

    // MXL is 1 for RV32, extensions are A, C, I and M.
    localparam logic [xlen-1:0] misa_value = 32'h4000_1105;
    // Architecture ID.
    localparam logic [xlen-1:0] marchid_value = 32'd37;
    // Major version 2, minor and patch zero.
    localparam logic [xlen-1:0] mimpid_value = 32'h0000_0200;
    // Single hart.
    localparam logic [xlen-1:0] hartid_value = 32'd0;

    // Pending bit of the machine timer interrupt.
    localparam int irq_timer_bit = 7;
    // First pending bit of the external lines.
    localparam int irq_ext_lo = 16;

    // Cycles MIE must be stable before an interrupt is taken.
    localparam int mie_settle = 2;

endpackage

`default_nettype wire

// File: logic/csr_bus_if.sv
// CSR access bus between the top level and the machine CSR register file.
`timescale 1ns/1ns
`default_nettype none

interface csr_bus_if;
    import trap_pkg::*;

    // Access address.
    logic [csr_addr_w-1:0] addr;
    // Write strobe, one cycle.
    logic                  we;
    // Write data.
    logic [xlen-1:0]       wdata;
    // Read data, same cycle as addr.
    logic [xlen-1:0]       rdata;
    // Address is implemented.
    logic                  exists;
    // Address ignores writes.
    logic                  rdonly;

    // Side that issues accesses.
    modport host (
        output addr, we, wdata,
        input  rdata, exists, rdonly
    );

    // Side that stores and decodes.
    modport regs (
        input  addr, we, wdata,
        output rdata, exists, rdonly
    );

endinterface

`default_nettype wire

// File: logic/trap_bus_if.sv
// Exception bus linking the trap dispatcher, interrupt arbiter and CSR file.
`timescale 1ns/1ns
`default_nettype none

interface trap_bus_if;
    import trap_pkg::*;

    // Dispatcher outputs.
    logic               ex_trap;
    logic               ex_irq;
    logic [cause_w-1:0] ex_cause;
    logic [xlen-1:0]    ex_epc;
    logic               ret;
    priv_e              ex_pp;

    // Arbiter outputs.
    logic [xlen-1:0]    irq_ip;
    logic [cause_w-1:0] irq_cause;
    logic               irq_ok;

    // CSR file outputs.
    logic [xlen-1:0]    irq_mie;
    logic               status_mie;
    priv_e              status_mpp;
    logic               status_mprv;
    logic [xlen-1:0]    ex_tvec;
    logic [xlen-1:0]    ret_epc;

    modport dispatch (
        output ex_trap, ex_irq, ex_cause, ex_epc, ret, ex_pp,
        input  irq_cause, irq_ok, status_mpp, status_mprv, ex_tvec, ret_epc
    );

    modport arbiter (
        output irq_ip, irq_cause, irq_ok,
        input  irq_mie, status_mie
    );

    modport regs (
        output irq_mie, status_mie, status_mpp, status_mprv, ex_tvec, ret_epc,
        input  ex_trap, ex_irq, ex_cause, ex_epc, ret, ex_pp, irq_ip
    );

endinterface

`default_nettype wire

// File: logic/csr_file.sv
// Machine CSR file with read decode and trap, return and write updates.
`timescale 1ns/1ns
`default_nettype none

module csr_file (
    input  wire logic clk,
    input  wire logic rst,
    csr_bus_if.regs   csr,
    trap_bus_if.regs  tb
);
    import trap_pkg::*;

    // mstatus fields.
    logic               st_mie;
    logic               st_mpie;
    priv_e              st_mpp;
    logic               st_mprv;
    // Per-interrupt enables.
    logic [xlen-1:0]    mie_r;
    // Vector base in direct mode only.
    logic [xlen-1:2]    mtvec_r;
    logic [xlen-1:0]    mscratch_r;
    logic [xlen-1:1]    mepc_r;
    // mcause split into flag and number.
    logic               mcause_int;
    logic [cause_w-1:0] mcause_no;

    // Assembled views.
    logic [xlen-1:0]    mstatus_word;
    logic [xlen-1:0]    mcause_word;
    logic [xlen-1:0]    mip_word;

    assign mstatus_word = {14'b0, st_mprv, 4'b0, st_mpp, 3'b0, st_mpie, 3'b0, st_mie, 3'b0};
    assign mcause_word  = {mcause_int, {(xlen-cause_w-1){1'b0}}, mcause_no};
    // Only enabled sources show as pending.
    assign mip_word     = tb.irq_ip & mie_r;

    // Status towards dispatcher and arbiter.
    assign tb.irq_mie     = mie_r;
    assign tb.status_mie  = st_mie;
    assign tb.status_mpp  = st_mpp;
    assign tb.status_mprv = st_mprv;
    assign tb.ex_tvec     = {mtvec_r, 2'b00};
    assign tb.ret_epc     = {mepc_r, 1'b0};

    // Read decode.
    always_comb begin
        csr.exists = 1'b1;
        csr.rdonly = 1'b0;
        csr.rdata  = '0;
        case (csr.addr)
            csr_mstatus:    csr.rdata = mstatus_word;
            // Fixed ISA word.
            csr_misa: begin
                csr.rdonly = 1'b1;
                csr.rdata  = misa_value;
            end
            csr_medeleg:    csr.rdata = '0;
            csr_mideleg:    csr.rdata = '0;
            csr_mie:        csr.rdata = mie_r;
            csr_mtvec:      csr.rdata = {mtvec_r, 2'b00};
            csr_mstatush:   csr.rdata = '0;
            csr_mscratch:   csr.rdata = mscratch_r;
            csr_mepc:       csr.rdata = {mepc_r, 1'b0};
            csr_mcause:     csr.rdata = mcause_word;
            csr_mtval:      csr.rdata = '0;
            csr_mip:        csr.rdata = mip_word;
            // ID registers never change.
            csr_mvendorid: begin
                csr.rdonly = 1'b1;
            end
            csr_marchid: begin
                csr.rdonly = 1'b1;
                csr.rdata  = marchid_value;
            end
            csr_mimpid: begin
                csr.rdonly = 1'b1;
                csr.rdata  = mimpid_value;
            end
            csr_mhartid: begin
                csr.rdonly = 1'b1;
                csr.rdata  = hartid_value;
            end
            csr_mconfigptr: begin
                csr.rdonly = 1'b1;
            end
            default: begin
                csr.exists = 1'b0;
            end
        endcase
    end

    // Trap beats return and return beats software write.
    always_ff @(posedge clk) begin
        if (rst) begin
            st_mie     <= 1'b0;
            st_mpie    <= 1'b0;
            st_mpp     <= priv_machine;
            st_mprv    <= 1'b0;
            mie_r      <= '0;
            mtvec_r    <= '0;
            mscratch_r <= '0;
            mepc_r     <= '0;
            mcause_int <= 1'b0;
            mcause_no  <= '0;
        end else if (tb.ex_trap || tb.ex_irq) begin
            // Stack the enable and privilege.
            st_mpie    <= st_mie;
            st_mie     <= 1'b0;
            st_mpp     <= tb.ex_pp;
            mepc_r     <= tb.ex_epc[xlen-1:1];
            mcause_int <= tb.ex_irq;
            mcause_no  <= tb.ex_cause;
        end else if (tb.ret) begin
            // Unstack and keep MPRV only on a return to M.
            st_mie  <= st_mpie;
            st_mprv <= st_mprv && (st_mpp == priv_machine);
        end else if (csr.we) begin
            case (csr.addr)
                csr_mstatus: begin
                    st_mie  <= csr.wdata[3];
                    st_mpie <= csr.wdata[7];
                    // Only U and M exist, so any nonzero MPP means M.
                    st_mpp  <= (csr.wdata[12:11] != 2'b00) ? priv_machine : priv_user;
                    st_mprv <= csr.wdata[17];
                end
                csr_mie:      mie_r      <= csr.wdata;
                csr_mtvec:    mtvec_r    <= csr.wdata[xlen-1:2];
                csr_mscratch: mscratch_r <= csr.wdata;
                csr_mepc:     mepc_r     <= csr.wdata[xlen-1:1];
                csr_mcause: begin
                    mcause_int <= csr.wdata[xlen-1];
                    mcause_no  <= csr.wdata[cause_w-1:0];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/irq_arbiter.sv
// Interrupt latch, mask, priority encoder and MIE settle filter.
`timescale 1ns/1ns
`default_nettype none

module irq_arbiter (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic timer_irq,
    input  wire logic [trap_pkg::xlen-trap_pkg::irq_ext_lo-1:0] ext_irq,
    trap_bus_if.arbiter tb
);
    import trap_pkg::*;

    // Raw pending word before the latch.
    logic [xlen-1:0]       pend_next;
    // Pending and enabled.
    logic [xlen-1:0]       irq_masked;
    // History of mstatus.MIE.
    logic [mie_settle-1:0] mie_hist;

    // Timer at bit 7, external lines in the upper half.
    always_comb begin
        pend_next = '0;
        pend_next[irq_timer_bit] = timer_irq;
        pend_next[xlen-1:irq_ext_lo] = ext_irq;
    end

    // Inputs show up one edge later.
    always_ff @(posedge clk) begin
        if (rst) begin
            tb.irq_ip <= '0;
        end else begin
            tb.irq_ip <= pend_next;
        end
    end

    assign irq_masked = tb.irq_ip & tb.irq_mie;

    // Lowest set bit wins.
    always_comb begin
        tb.irq_cause = '0;
        for (int i = xlen - 1; i >= 0; i--) begin
            if (irq_masked[i]) begin
                tb.irq_cause = i[cause_w-1:0];
            end
        end
    end

    // Shift in MIE each cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= (mie_hist << 1) | mie_settle'(tb.status_mie);
        end
    end

    // MIE must be stable and still set.
    assign tb.irq_ok = (&mie_hist) && tb.status_mie && (tb.irq_cause != '0);

endmodule

`default_nettype wire

// File: logic/trap_dispatch.sv
// Picks interrupt, trap or return per cycle and keeps the privilege level.
`timescale 1ns/1ns
`default_nettype none

module trap_dispatch (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic retire_valid,
    input  wire logic retire_trap,
    input  wire logic mret,
    input  wire logic [trap_pkg::xlen-1:0] retire_pc,
    input  wire logic [3:0] retire_cause,
    trap_bus_if.dispatch tb,
    output trap_pkg::priv_e cur_priv,
    output trap_pkg::priv_e data_priv,
    output logic exception,
    output logic exc_is_irq,
    output logic [trap_pkg::cause_w-1:0] exc_cause,
    output logic [trap_pkg::xlen-1:0] exc_tvec,
    output logic [trap_pkg::xlen-1:0] ret_epc
);
    import trap_pkg::*;

    // Outcome of the current cycle.
    typedef enum logic [1:0] {
        act_none,
        act_irq,
        act_trap,
        act_ret
    } act_e;

    act_e act;

    // Interrupt over trap over return.
    always_comb begin
        act = act_none;
        if (retire_valid && tb.irq_ok) begin
            act = act_irq;
        end else if (retire_valid && retire_trap) begin
            act = act_trap;
        end else if (mret) begin
            act = act_ret;
        end
    end

    assign tb.ex_irq   = (act == act_irq);
    assign tb.ex_trap  = (act == act_trap);
    assign tb.ret      = (act == act_ret);
    // Trap causes are 4 bits, zero-extended.
    assign tb.ex_cause = (act == act_irq) ? tb.irq_cause : {1'b0, retire_cause};
    // Both exception kinds return to the retiring PC.
    assign tb.ex_epc   = retire_pc;
    assign tb.ex_pp    = cur_priv;

    // Privilege register.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_priv <= priv_machine;
        end else if (act == act_irq || act == act_trap) begin
            cur_priv <= priv_machine;
        end else if (act == act_ret) begin
            cur_priv <= tb.status_mpp;
        end
    end

    // Loads and stores use MPP when MPRV is set.
    assign data_priv  = tb.status_mprv ? tb.status_mpp : cur_priv;

    // Exception outputs, same cycle as the retire.
    assign exception  = tb.ex_trap || tb.ex_irq;
    assign exc_is_irq = tb.ex_irq;
    assign exc_cause  = exception ? tb.ex_cause : '0;
    assign exc_tvec   = tb.ex_tvec;
    assign ret_epc    = tb.ret_epc;

endmodule

`default_nettype wire

// File: logic/trap_unit.sv
// Top level of the machine-mode trap and CSR unit.
`timescale 1ns/1ns
`default_nettype none

module trap_unit (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic retire_valid,
    input  wire logic retire_trap,
    input  wire logic [trap_pkg::xlen-1:0] retire_pc,
    input  wire logic [3:0] retire_cause,
    input  wire logic mret,
    input  wire logic timer_irq,
    input  wire logic [trap_pkg::xlen-trap_pkg::irq_ext_lo-1:0] ext_irq,
    input  wire logic [trap_pkg::csr_addr_w-1:0] csr_addr,
    input  wire logic csr_we,
    input  wire logic [trap_pkg::xlen-1:0] csr_wdata,
    output logic [trap_pkg::xlen-1:0] csr_rdata,
    output logic csr_exists,
    output logic csr_rdonly,
    output logic exception,
    output logic exc_is_irq,
    output logic [trap_pkg::cause_w-1:0] exc_cause,
    output logic [trap_pkg::xlen-1:0] exc_tvec,
    output logic [trap_pkg::xlen-1:0] ret_epc,
    output trap_pkg::priv_e cur_priv,
    output trap_pkg::priv_e data_priv
);

    csr_bus_if  csr_bus ();
    trap_bus_if trap_bus ();

    // Host side of the CSR bus.
    assign csr_bus.addr  = csr_addr;
    assign csr_bus.we    = csr_we;
    assign csr_bus.wdata = csr_wdata;
    assign csr_rdata     = csr_bus.rdata;
    assign csr_exists    = csr_bus.exists;
    assign csr_rdonly    = csr_bus.rdonly;

    csr_file u_csr_file (
        .clk (clk),
        .rst (rst),
        .csr (csr_bus),
        .tb  (trap_bus)
    );

    irq_arbiter u_irq_arbiter (
        .clk       (clk),
        .rst       (rst),
        .timer_irq (timer_irq),
        .ext_irq   (ext_irq),
        .tb        (trap_bus)
    );

    trap_dispatch u_trap_dispatch (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .mret         (mret),
        .retire_pc    (retire_pc),
        .retire_cause (retire_cause),
        .tb           (trap_bus),
        .cur_priv     (cur_priv),
        .data_priv    (data_priv),
        .exception    (exception),
        .exc_is_irq   (exc_is_irq),
        .exc_cause    (exc_cause),
        .exc_tvec     (exc_tvec),
        .ret_epc      (ret_epc)
    );

endmodule

`default_nettype wire

// File: bench/trap_unit_tb.sv
// Directed testbench for the machine-mode trap and CSR unit.
`timescale 1ns/1ns
`default_nettype none

module trap_unit_tb;
    import trap_pkg::*;

    // The tests take about 200 cycles.
    localparam int max_cycles = 2000;

    logic        clk;
    logic        rst;
    logic        retire_valid;
    logic        retire_trap;
    logic [31:0] retire_pc;
    logic [3:0]  retire_cause;
    logic        mret;
    logic        timer_irq;
    logic [15:0] ext_irq;
    logic [11:0] csr_addr;
    logic        csr_we;
    logic [31:0] csr_wdata;
    logic [31:0] csr_rdata;
    logic        csr_exists;
    logic        csr_rdonly;
    logic        exception;
    logic        exc_is_irq;
    logic [4:0]  exc_cause;
    logic [31:0] exc_tvec;
    logic [31:0] ret_epc;
    priv_e       cur_priv;
    priv_e       data_priv;

    int     errors;
    int     tests_run;
    int     tests_failed;
    int     cycle_count;
    integer seed;

    trap_unit u_dut (
        .clk          (clk),
        .rst          (rst),
        .retire_valid (retire_valid),
        .retire_trap  (retire_trap),
        .retire_pc    (retire_pc),
        .retire_cause (retire_cause),
        .mret         (mret),
        .timer_irq    (timer_irq),
        .ext_irq      (ext_irq),
        .csr_addr     (csr_addr),
        .csr_we       (csr_we),
        .csr_wdata    (csr_wdata),
        .csr_rdata    (csr_rdata),
        .csr_exists   (csr_exists),
        .csr_rdonly   (csr_rdonly),
        .exception    (exception),
        .exc_is_irq   (exc_is_irq),
        .exc_cause    (exc_cause),
        .exc_tvec     (exc_tvec),
        .ret_epc      (ret_epc),
        .cur_priv     (cur_priv),
        .data_priv    (data_priv)
    );

    // 20 ns period.
    always #10 clk = ~clk;

    // Next drive point 2 ns past the rising edge.
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    endtask

    // One-cycle write strobe.
    task automatic csr_wr(input logic [11:0] addr, input logic [31:0] data);
        csr_addr  = addr;
        csr_wdata = data;
        csr_we    = 1'b1;
        step();
        csr_we    = 1'b0;
    endtask

    // Read is combinational and sampled mid-cycle.
    task automatic csr_check(input logic [11:0] addr, input string name,
                             input logic [31:0] exp, input logic exp_ro);
        csr_addr = addr;
        csr_we   = 1'b0;
        #5;
        if (csr_rdata !== exp) report_mismatch(name, csr_rdata, exp);
        if (csr_exists !== 1'b1) report_mismatch("csr_exists", 32'(csr_exists), 32'd1);
        if (csr_rdonly !== exp_ro) report_mismatch("csr_rdonly", 32'(csr_rdonly), 32'(exp_ro));
        step();
    endtask

    task automatic priv_check(input priv_e exp_cur, input priv_e exp_data);
        #5;
        if (cur_priv !== exp_cur) report_mismatch("cur_priv", 32'(cur_priv), 32'(exp_cur));
        if (data_priv !== exp_data) report_mismatch("data_priv", 32'(data_priv), 32'(exp_data));
        step();
    endtask

    // Retire a faulting instruction and check the same-cycle exception.
    task automatic retire_check(input logic [31:0] pc, input logic [3:0] cause,
                                input logic exp_irq, input logic [4:0] exp_cause,
                                input logic [31:0] exp_tvec);
        retire_valid = 1'b1;
        retire_trap  = 1'b1;
        retire_pc    = pc;
        retire_cause = cause;
        #5;
        if (exception !== 1'b1) report_mismatch("exception", 32'(exception), 32'd1);
        if (exc_is_irq !== exp_irq) report_mismatch("exc_is_irq", 32'(exc_is_irq), 32'(exp_irq));
        if (exc_cause !== exp_cause) report_mismatch("exc_cause", 32'(exc_cause), 32'(exp_cause));
        if (exc_tvec !== exp_tvec) report_mismatch("exc_tvec", exc_tvec, exp_tvec);
        step();
        retire_valid = 1'b0;
        retire_trap  = 1'b0;
    endtask

    task automatic finish_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_before);
        end
    endtask

    task automatic constants_after_reset();
        int err_before;
        err_before = errors;
        // Only MPP is set to machine.
        csr_check(csr_mstatus, "mstatus", 32'h0000_1800, 1'b0);
        // MXL 1 with A, C, I and M.
        csr_check(csr_misa, "misa", (32'd1 << 30) | (32'd1 << 12) | (32'd1 << 8) |
                  (32'd1 << 2) | 32'd1, 1'b1);
        csr_check(csr_marchid, "marchid", 32'd37, 1'b1);
        csr_check(csr_mimpid, "mimpid", 32'd2 << 8, 1'b1);
        csr_check(csr_mhartid, "mhartid", 32'd0, 1'b1);
        // Writable registers clear on reset.
        csr_check(csr_mie, "mie", 32'd0, 1'b0);
        csr_check(csr_mtvec, "mtvec", 32'd0, 1'b0);
        csr_check(csr_mscratch, "mscratch", 32'd0, 1'b0);
        csr_check(csr_mepc, "mepc", 32'd0, 1'b0);
        csr_check(csr_mcause, "mcause", 32'd0, 1'b0);
        csr_addr = 12'h7c0;
        #5;
        if (csr_exists !== 1'b0) report_mismatch("csr_exists", 32'(csr_exists), 32'd0);
        if (exception !== 1'b0) report_mismatch("exception", 32'(exception), 32'd0);
        if (exc_is_irq !== 1'b0) report_mismatch("exc_is_irq", 32'(exc_is_irq), 32'd0);
        step();
        priv_check(priv_machine, priv_machine);
        finish_test("reset_constants", err_before);
    endtask

    task automatic read_write_fields();
        int          err_before;
        logic [31:0] val;
        err_before = errors;
        val = $random(seed);
        csr_wr(csr_mscratch, val);
        csr_check(csr_mscratch, "mscratch", val, 1'b0);
        // Alignment bits read as zero.
        csr_wr(csr_mtvec, 32'hffff_ffff);
        csr_check(csr_mtvec, "mtvec", 32'hffff_fffc, 1'b0);
        csr_wr(csr_mepc, 32'hffff_ffff);
        csr_check(csr_mepc, "mepc", 32'hffff_fffe, 1'b0);
        // Flag in bit 31 and a five-bit number.
        csr_wr(csr_mcause, 32'hffff_ffff);
        csr_check(csr_mcause, "mcause", 32'h8000_001f, 1'b0);
        csr_wr(csr_marchid, 32'h0);
        csr_check(csr_marchid, "marchid", 32'd37, 1'b1);
        finish_test("read_write", err_before);
    endtask

    task automatic sync_trap_entry();
        int          err_before;
        logic [31:0] pc;
        logic [31:0] tvec;
        err_before = errors;
        pc   = $random(seed);
        tvec = $random(seed) & 32'hffff_fffc;
        csr_wr(csr_mtvec, tvec);
        csr_wr(csr_mie, 32'h0);
        // MIE on and MPP machine.
        csr_wr(csr_mstatus, 32'h0000_1808);
        retire_check(pc, 4'd2, 1'b0, 5'd2, tvec);
        csr_check(csr_mepc, "mepc", pc & 32'hffff_fffe, 1'b0);
        csr_check(csr_mcause, "mcause", 32'd2, 1'b0);
        // MIE stacked into MPIE and MPP is machine.
        csr_check(csr_mstatus, "mstatus", 32'h0000_1880, 1'b0);
        finish_test("sync_trap", err_before);
    endtask

    task automatic mret_and_priv();
        int          err_before;
        logic [31:0] epc;
        logic [31:0] tvec;
        err_before = errors;
        epc  = $random(seed) & 32'hffff_fffe;
        tvec = $random(seed) & 32'hffff_fffc;
        csr_wr(csr_mepc, epc);
        csr_wr(csr_mtvec, tvec);
        // MPRV and MPIE set with MPP user.
        csr_wr(csr_mstatus, 32'h0002_0080);
        priv_check(priv_machine, priv_user);
        mret = 1'b1;
        #5;
        if (ret_epc !== epc) report_mismatch("ret_epc", ret_epc, epc);
        if (exception !== 1'b0) report_mismatch("exception", 32'(exception), 32'd0);
        step();
        mret = 1'b0;
        priv_check(priv_user, priv_user);
        // MIE restored and MPRV dropped on return to user.
        csr_check(csr_mstatus, "mstatus", 32'h0000_0088, 1'b0);
        // Trap from user mode.
        retire_check(epc, 4'd8, 1'b0, 5'd8, tvec);
        priv_check(priv_machine, priv_machine);
        csr_check(csr_mstatus, "mstatus", 32'h0000_0080, 1'b0);
        csr_check(csr_mcause, "mcause", 32'd8, 1'b0);
        finish_test("return_priv", err_before);
    endtask

    task automatic irq_priority();
        int          err_before;
        logic [31:0] pc;
        logic [31:0] tvec;
        err_before = errors;
        pc   = $random(seed);
        tvec = $random(seed) & 32'hffff_fffc;
        csr_wr(csr_mtvec, tvec);
        csr_wr(csr_mie, (32'd1 << 7) | (32'd1 << 20));
        csr_wr(csr_mstatus, 32'h0000_1808);
        ext_irq   = 16'h0010;
        timer_irq = 1'b1;
        // Let the pending latch and MIE history fill.
        repeat (3) step();
        csr_check(csr_mip, "mip", (32'd1 << 7) | (32'd1 << 20), 1'b0);
        // Timer beats the external line and the trap.
        retire_check(pc, 4'd2, 1'b1, 5'd7, tvec);
        csr_check(csr_mepc, "mepc", pc & 32'hffff_fffe, 1'b0);
        csr_check(csr_mcause, "mcause", 32'h8000_0007, 1'b0);
        csr_check(csr_mstatus, "mstatus", 32'h0000_1880, 1'b0);
        // MIE set one cycle ago has not settled yet.
        csr_wr(csr_mstatus, 32'h0000_1808);
        retire_check(pc, 4'd2, 1'b0, 5'd2, tvec);
        // Masked sources.
        csr_wr(csr_mie, 32'h0);
        csr_wr(csr_mstatus, 32'h0000_1808);
        repeat (3) step();
        pc = $random(seed);
        retire_check(pc, 4'd2, 1'b0, 5'd2, tvec);
        timer_irq = 1'b0;
        ext_irq   = 16'h0;
        finish_test("interrupts", err_before);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        retire_valid = 1'b0;
        retire_trap  = 1'b0;
        retire_pc    = 32'h0;
        retire_cause = 4'h0;
        mret         = 1'b0;
        timer_irq    = 1'b0;
        ext_irq      = 16'h0;
        csr_addr     = 12'h0;
        csr_we       = 1'b0;
        csr_wdata    = 32'h0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        seed         = 32'hd5e8_9fa2;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        constants_after_reset();
        read_write_fields();
        sync_trap_entry();
        mret_and_priv();
        irq_priority();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // Stops a stuck run.
    initial begin
        cycle_count = 0;
        while (cycle_count < max_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, run stopped after %0d cycles", max_cycles);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
logic/trap_pkg.sv
logic/csr_bus_if.sv
logic/trap_bus_if.sv
logic/csr_file.sv
logic/irq_arbiter.sv
logic/trap_dispatch.sv
logic/trap_unit.sv
bench/trap_unit_tb.sv

// File: Makefile
# Verilator build and run of the trap unit testbench.
SRCS := $(shell cat sources.f)

run: obj_dir/Vtrap_unit_tb
	./obj_dir/Vtrap_unit_tb | tee sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

obj_dir/Vtrap_unit_tb: sources.f $(SRCS)
	verilator --binary --timing --top-module trap_unit_tb -f sources.f -Mdir obj_dir

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
